// ==== tb.f ====
rtl/rv_exec_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_exu.sv
rtl/rv_csr_file.sv
rtl/rv_exec_core.sv
test/tb_rv_exec_core.sv

// ==== Bender.yml ====
package:
  name: rv_exec_core

sources:
  - rtl/rv_exec_pkg.sv
  - rtl/rv_decoder.sv
  - rtl/rv_regfile.sv
  - rtl/rv_exu.sv
  - rtl/rv_csr_file.sv
  - rtl/rv_exec_core.sv
  - target: test
    files:
      - test/tb_rv_exec_core.sv

// ==== test/tb_rv_exec_core.sv ====
`timescale 1ns/1ps

module tb_rv_exec_core import rv_exec_pkg::*; ();

	localparam int n_directed = 30;
	localparam int n_followup = 6;
	localparam int n_random = 200;
	localparam int cycle_limit = (n_directed + n_followup + n_random) * 8 + 100;

	// x1 = -5 and x2 = 3 feed most of the directed checks below.
	localparam logic [31:0] directed [n_directed] = '{
		32'hffb0_0093, // addi x1, x0, -5
		32'h0030_0113, // addi x2, x0, 3
		32'h8000_01b7, // lui x3, 0x80000
		32'h4020_8233, // sub x4, x1, x2
		32'h0020_8033, // add x0, x1, x2
		32'h0000_02b3, // add x5, x0, x0
		32'h4021_d333, // sra x6, x3, x2
		32'h0021_d3b3, // srl x7, x3, x2
		32'h0020_a433, // slt x8, x1, x2
		32'h0020_b4b3, // sltu x9, x1, x2
		32'h4041_d513, // srai x10, x3, 4
		32'hfff0_b593, // sltiu x11, x1, -1
		32'h0020_fab3, // and x21, x1, x2
		32'h0020_eb33, // or x22, x1, x2
		32'h0020_cbb3, // xor x23, x1, x2
		32'h0020_9c33, // sll x24, x1, x2
		32'h1234_5617, // auipc x12, 0x12345
		32'hff1f_f6ef, // jal x13, -16
		32'h0021_0767, // jalr x14, 2(x2), odd target
		32'h0021_0463, // beq x2, x2, 8
		32'h0020_9463, // bne x1, x2, 8
		32'h0020_c463, // blt x1, x2, 8
		32'h0020_d463, // bge x1, x2, 8
		32'h0020_e463, // bltu x1, x2, 8
		32'h0020_f463, // bgeu x1, x2, 8
		32'h0020_80a3, // sb x2, 1(x1)
		32'h0020_90a3, // sh x2, 1(x1)
		32'h0020_a0a3, // sw x2, 1(x1)
		32'h3051_17f3, // csrrw x15, mtvec, x2
		32'h3050_a873  // csrrs x16, mtvec, x1
	};

	logic clk;
	logic rst;
	logic req;
	cmd_t cmd;
	logic ack;
	result_t res;

	result_t exp_res;
	logic [31:0] xregs [32];
	logic [31:0] csrs [4];
	logic [31:0] seed = 32'h4e81_ad06;
	int value_errors = 0;
	int handshake_errors = 0;
	int cycles = 0;

	rv_exec_core rv_exec_core_inst (
		.clk (clk),
		.rst (rst),
		.req (req),
		.cmd (cmd),
		.ack (ack),
		.res (res)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
		input logic arith, input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return sub ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: begin
				if (arith)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic taken_ref(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic int csr_slot(input logic [11:0] addr);
		case (addr)
			CSR_MSTATUS: return 0;
			CSR_MTVEC: return 1;
			CSR_MEPC: return 2;
			CSR_MCAUSE: return 3;
			default: return -1;
		endcase
	endfunction

	// computes the expected result bundle and then updates the shadow state.
	task automatic predict(input logic [31:0] instr, input logic [31:0] pc);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] val;
		logic [31:0] old_csr;
		logic [2:0] f3;
		int slot;
		f3 = instr[14:12];
		a = xregs[instr[19:15]];
		b = xregs[instr[24:20]];
		imm_i = {{20{instr[31]}}, instr[31:20]};
		slot = csr_slot(instr[31:20]);
		old_csr = (slot < 0) ? 32'd0 : csrs[slot];
		val = '0;
		exp_res = '0;
		exp_res.rd = instr[11:7];
		exp_res.rd_we = 1'b1;
		exp_res.next_pc = pc + 32'd4;
		case (instr[6:0])
			OPC_LUI: val = {instr[31:12], 12'b0};
			OPC_AUIPC: val = pc + {instr[31:12], 12'b0};
			OPC_JAL: begin
				val = pc + 32'd4;
				exp_res.next_pc = pc + {{12{instr[31]}}, instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			OPC_JALR: begin
				val = pc + 32'd4;
				exp_res.next_pc = (a + imm_i) & ~32'd1;
			end
			OPC_OPIMM: val = alu_ref(f3, 1'b0, instr[30], a, imm_i);
			OPC_OP: val = alu_ref(f3, instr[30], instr[30], a, b);
			OPC_BRANCH: begin
				exp_res.rd_we = 1'b0;
				if (taken_ref(f3, a, b))
					exp_res.next_pc = pc + {{20{instr[31]}}, instr[7], instr[30:25],
						instr[11:8], 1'b0};
			end
			OPC_STORE: begin
				exp_res.rd_we = 1'b0;
				exp_res.store_en = 1'b1;
				exp_res.wmask = (f3 == 3'd0) ? 4'h1 : (f3 == 3'd1) ? 4'h3 : 4'hf;
				exp_res.store_addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
				exp_res.store_data = b;
			end
			OPC_SYSTEM: begin
				if (f3 == 3'b001 || f3 == 3'b010) begin
					val = old_csr;
					if (slot >= 0)
						csrs[slot] = (f3 == 3'b010) ? (a | old_csr) : a;
				end else begin
					exp_res.rd_we = 1'b0;
					exp_res.illegal = 1'b1;
				end
			end
			default: begin
				exp_res.rd_we = 1'b0;
				exp_res.illegal = 1'b1;
			end
		endcase
		exp_res.rd_val = exp_res.rd_we ? val : 32'd0;
		if (exp_res.rd_we && instr[11:7] != 5'd0)
			xregs[instr[11:7]] = val;
	endtask

	// registers stay within x0..x7 so that results get reused as operands.
	function automatic logic [31:0] rand_instr();
		logic [31:0] r;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [11:0] imm;
		int sel;
		r = next_rand();
		sel = int'(next_rand() % 32'd9);
		rd = {2'b00, r[18:16]};
		rs1 = {2'b00, r[21:19]};
		rs2 = {2'b00, r[24:22]};
		f3 = r[27:25];
		imm = r[11:0];
		case (sel)
			0: return {1'b0, r[28], 5'b0, rs2, rs1, f3, rd, OPC_OP};
			1: begin
				if (f3 == 3'b001 || f3 == 3'b101)
					imm = {1'b0, r[28] & f3[2], 5'b0, r[4:0]};
				return {imm, rs1, f3, rd, OPC_OPIMM};
			end
			2: return {r[31:12], rd, OPC_LUI};
			3: return {r[31:12], rd, OPC_AUIPC};
			4: return {r[31:12], rd, OPC_JAL};
			5: return {imm, rs1, 3'b000, rd, OPC_JALR};
			6: begin
				if (f3[2:1] == 2'b01)
					f3 = {1'b1, f3[1:0]};
				return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_BRANCH};
			end
			7: begin
				f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
				return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
			end
			default: begin
				case (r[30:28])
					3'd0: imm = CSR_MSTATUS;
					3'd1: imm = CSR_MTVEC;
					3'd2: imm = CSR_MEPC;
					3'd3: imm = CSR_MCAUSE;
					default: imm = 12'h340;
				endcase
				f3 = r[31] ? 3'b010 : 3'b001;
				return {imm, rs1, f3, rd, OPC_SYSTEM};
			end
		endcase
	endfunction

	// one full four-phase transfer, started right after a rising edge.
	task automatic send(input logic [31:0] instr, input logic [31:0] pc);
		int extra;
		extra = int'(next_rand() % 32'd4);
		predict(instr, pc);
		cmd <= '{instr: instr, pc: pc};
		req <= 1'b1;
		@(posedge clk);
		while (!ack)
			@(posedge clk);
		repeat (extra) @(posedge clk);
		req <= 1'b0;
		@(posedge clk);
		while (ack)
			@(posedge clk);
	endtask

	task automatic field_error(input string name, input logic [31:0] got,
		input logic [31:0] want);
		value_errors++;
		$display("Error at %0t: res.%s is %h, expected %h", $time, name, got, want);
	endtask

	task automatic handshake_error(input string what);
		handshake_errors++;
		$display("Handshake failure at %0t: %s.", $time, what);
	endtask

	property at_ack(ok);
		@(posedge clk) disable iff (rst) $rose(ack) |-> ok;
	endproperty

	a_rd: assert property (at_ack(res.rd == exp_res.rd))
		else field_error("rd", res.rd, exp_res.rd);
	a_rd_we: assert property (at_ack(res.rd_we == exp_res.rd_we))
		else field_error("rd_we", res.rd_we, exp_res.rd_we);
	a_rd_val: assert property (at_ack(res.rd_val == exp_res.rd_val))
		else field_error("rd_val", res.rd_val, exp_res.rd_val);
	a_next_pc: assert property (at_ack(res.next_pc == exp_res.next_pc))
		else field_error("next_pc", res.next_pc, exp_res.next_pc);
	a_store_en: assert property (at_ack(res.store_en == exp_res.store_en))
		else field_error("store_en", res.store_en, exp_res.store_en);
	a_wmask: assert property (at_ack(res.wmask == exp_res.wmask))
		else field_error("wmask", res.wmask, exp_res.wmask);
	a_store_addr: assert property (at_ack(res.store_addr == exp_res.store_addr))
		else field_error("store_addr", res.store_addr, exp_res.store_addr);
	a_store_data: assert property (at_ack(res.store_data == exp_res.store_data))
		else field_error("store_data", res.store_data, exp_res.store_data);
	a_illegal: assert property (at_ack(res.illegal == exp_res.illegal))
		else field_error("illegal", res.illegal, exp_res.illegal);

	a_ack_delay: assert property (@(posedge clk) disable iff (rst)
		$rose(req) |-> ##2 $rose(ack))
		else handshake_error("ack did not rise two edges after req was sampled high");
	a_ack_hold: assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
		else handshake_error("ack dropped while req was still high");
	a_ack_drop: assert property (@(posedge clk) disable iff (rst) $fell(req) |-> ack ##1 !ack)
		else handshake_error("ack did not fall one edge after req went low");
	a_ack_reset: assert property (@(posedge clk) rst |=> !ack)
		else handshake_error("ack was high right after reset");

	initial begin
		logic [31:0] instr;
		logic [31:0] pc;
		rst = 1'b1;
		req = 1'b0;
		cmd = '0;
		foreach (xregs[i])
			xregs[i] = '0;
		foreach (csrs[i])
			csrs[i] = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < n_directed; i++) begin
			send(directed[i], 32'h1000 + 32'(i) * 32'd4);
		end
		send(32'h3050_28f3, 32'h2000); // csrrs x17, mtvec, x0 reads the new value
		send(32'h3400_9973, 32'h2004); // csrrw x18, 0x340, x1 is unimplemented
		send(32'h3400_29f3, 32'h2008); // csrrs x19, 0x340, x0 reads zero
		send(32'hffff_f0ff, 32'h200c); // unknown opcode aimed at x1
		send(32'h0000_0073, 32'h2010); // ecall is not supported
		send(32'h0000_8a33, 32'h2014); // add x20, x1, x0 still sees -5
		for (int i = 0; i < n_random; i++) begin
			pc = next_rand() & 32'hffff_fffc;
			instr = rand_instr();
			send(instr, pc);
		end
		repeat (2) @(posedge clk);
		$display("Finished: %0d value errors, %0d handshake errors",
			value_errors, handshake_errors);
		if (value_errors == 0 && handshake_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== rtl/rv_exec_core.sv ====
`timescale 1ns/1ps

module rv_exec_core import rv_exec_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    req,
	input  cmd_t    cmd,
	output logic    ack,
	output result_t res
);

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		EXEC = 2'd1,
		DONE = 2'd2
	} state_e;

	state_e state;
	cmd_t cmd_q;
	decoded_t dec;
	exu_out_t exu_out;
	result_t res_n;
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] csr_rdata;
	logic commit;

	rv_decoder rv_decoder_inst (
		.instr (cmd_q.instr),
		.dec   (dec)
	);

	rv_regfile rv_regfile_inst (
		.clk    (clk),
		.rst    (rst),
		.raddr1 (dec.rs1),
		.raddr2 (dec.rs2),
		.rdata1 (rs1_val),
		.rdata2 (rs2_val),
		.we     (commit && dec.rd_we),
		.waddr  (dec.rd),
		.wdata  (exu_out.val)
	);

	rv_csr_file rv_csr_file_inst (
		.clk   (clk),
		.rst   (rst),
		.addr  (dec.csr_addr),
		.rdata (csr_rdata),
		.we    (commit && exu_out.csr_we),
		.wdata (exu_out.csr_wdata)
	);

	rv_exu rv_exu_inst (
		.dec     (dec),
		.src1    (rs1_val),
		.src2    (rs2_val),
		.pc      (cmd_q.pc),
		.csr_val (csr_rdata),
		.out     (exu_out)
	);

	// state is only written during the single execute cycle.
	assign commit = (state == EXEC) && dec.legal;

	always_comb begin
		res_n            = '0;
		res_n.rd         = dec.rd;
		res_n.rd_we      = dec.rd_we && dec.legal;
		res_n.rd_val     = res_n.rd_we ? exu_out.val : '0;
		res_n.next_pc    = (dec.legal && exu_out.jump_en) ? exu_out.jump : cmd_q.pc + 32'd4;
		res_n.store_en   = dec.legal && exu_out.store_en;
		res_n.wmask      = exu_out.wmask;
		res_n.store_addr = exu_out.store_addr;
		res_n.store_data = exu_out.store_data;
		res_n.illegal    = !dec.legal;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			cmd_q <= '0;
			res   <= '0;
			ack   <= 1'b0;
		end else begin
			case (state)
				IDLE: if (req) begin
					cmd_q <= cmd;
					state <= EXEC;
				end
				EXEC: begin
					res   <= res_n;
					ack   <= 1'b1;
					state <= DONE;
				end
				DONE: if (!req) begin
					ack   <= 1'b0;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> req)
		else $error("rv_exec_core: ack rose without req");

	a_done_holds: assert property (@(posedge clk) disable iff (rst)
		(state == DONE && req) |=> (state == DONE))
		else $error("rv_exec_core: left DONE while req was high");

endmodule

// ==== rtl/rv_csr_file.sv ====
`timescale 1ns/1ps

module rv_csr_file import rv_exec_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic [11:0]     addr,
	output logic [XLEN-1:0] rdata,
	input  logic            we,
	input  logic [XLEN-1:0] wdata
);

	logic [XLEN-1:0] mstatus;
	logic [XLEN-1:0] mtvec;
	logic [XLEN-1:0] mepc;
	logic [XLEN-1:0] mcause;

	always_comb begin
		case (addr)
			CSR_MSTATUS: rdata = mstatus;
			CSR_MTVEC:   rdata = mtvec;
			CSR_MEPC:    rdata = mepc;
			CSR_MCAUSE:  rdata = mcause;
			default:     rdata = '0;
		endcase
	end

	// writes to any other address fall through and are dropped.
	always_ff @(posedge clk) begin
		if (rst) begin
			mstatus <= '0;
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
		end else if (we) begin
			case (addr)
				CSR_MSTATUS: mstatus <= wdata;
				CSR_MTVEC:   mtvec   <= wdata;
				CSR_MEPC:    mepc    <= wdata;
				CSR_MCAUSE:  mcause  <= wdata;
				default: ;
			endcase
		end
	end

	// the write data comes from the regfile through the execute unit.
	a_wdata_known: assert property (@(posedge clk) disable iff (rst)
		we |-> !$isunknown(wdata))
		else $error("rv_csr_file: write with unknown data");

endmodule

// ==== rtl/rv_exu.sv ====
`timescale 1ns/1ps

module rv_exu import rv_exec_pkg::*; (
	input  decoded_t        dec,
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] csr_val,
	output exu_out_t        out
);

	logic [XLEN-1:0] lop;
	logic [XLEN-1:0] rop;
	logic [XLEN-1:0] alu_res;
	logic [XLEN-1:0] jbase;
	logic [XLEN-1:0] jsum;
	logic [XLEN:0]   op_diff;
	logic [XLEN:0]   br_diff;
	logic [4:0]      shamt;
	logic op_less;
	logic br_less;
	logic br_equal;
	logic br_taken;
	logic is_store;
	alu_op_e alu_op;

	// operand selection, only the ALU-type opcodes feed real values.
	always_comb begin
		lop = '0;
		rop = '0;
		case (dec.opcode)
			OPC_LUI:            rop = dec.imm;
			OPC_AUIPC: begin
				lop = pc;
				rop = dec.imm;
			end
			OPC_JAL, OPC_JALR: begin
				lop = pc;
				rop = 32'd4;
			end
			OPC_OPIMM: begin
				lop = src1;
				rop = dec.imm;
			end
			OPC_OP: begin
				lop = src1;
				rop = src2;
			end
			default: ;
		endcase
	end

	always_comb begin
		alu_op = ALU_ADD;
		if (dec.opcode == OPC_OP || dec.opcode == OPC_OPIMM) begin
			case (dec.funct3)
				3'b000: alu_op = (dec.fmt == FMT_R && dec.funct7[5]) ? ALU_SUB : ALU_ADD;
				3'b001: alu_op = ALU_SLL;
				3'b010: alu_op = ALU_LESS;
				3'b011: alu_op = ALU_ULESS;
				3'b100: alu_op = ALU_XOR;
				3'b101: alu_op = dec.funct7[5] ? ALU_SRA : ALU_SRL;
				3'b110: alu_op = ALU_OR;
				default: alu_op = ALU_AND;
			endcase
		end
	end

	// the top bit of the widened difference is the unsigned borrow.
	assign op_diff = {1'b0, lop} - {1'b0, rop};
	assign op_less = (lop[XLEN-1] & ~rop[XLEN-1]) |
		(~(lop[XLEN-1] ^ rop[XLEN-1]) & op_diff[XLEN-1]);
	assign shamt = rop[4:0];

	always_comb begin
		case (alu_op)
			ALU_SUB:   alu_res = op_diff[XLEN-1:0];
			ALU_AND:   alu_res = lop & rop;
			ALU_XOR:   alu_res = lop ^ rop;
			ALU_OR:    alu_res = lop | rop;
			ALU_SRL:   alu_res = lop >> shamt;
			ALU_SRA:   alu_res = $signed(lop) >>> shamt;
			ALU_SLL:   alu_res = lop << shamt;
			ALU_LESS:  alu_res = {{(XLEN-1){1'b0}}, op_less};
			ALU_ULESS: alu_res = {{(XLEN-1){1'b0}}, op_diff[XLEN]};
			default:   alu_res = lop + rop;
		endcase
	end

	// Branch compare works on the raw register values.
	assign br_diff  = {1'b0, src1} - {1'b0, src2};
	assign br_equal = (br_diff[XLEN-1:0] == '0);
	assign br_less  = (src1[XLEN-1] & ~src2[XLEN-1]) |
		(~(src1[XLEN-1] ^ src2[XLEN-1]) & br_diff[XLEN-1]);

	always_comb begin
		case (dec.funct3)
			3'b000:  br_taken = br_equal;
			3'b001:  br_taken = ~br_equal;
			3'b100:  br_taken = br_less;
			3'b101:  br_taken = ~br_less;
			3'b110:  br_taken = br_diff[XLEN];
			3'b111:  br_taken = ~br_diff[XLEN];
			default: br_taken = 1'b0;
		endcase
	end

	assign jbase    = (dec.opcode == OPC_JALR) ? src1 : pc;
	assign jsum     = jbase + dec.imm;
	assign is_store = (dec.opcode == OPC_STORE);

	always_comb begin
		out          = '0;
		out.val      = dec.is_csr ? csr_val : alu_res;
		out.jump_en  = (dec.opcode == OPC_JAL) || (dec.opcode == OPC_JALR) ||
			((dec.opcode == OPC_BRANCH) && br_taken);
		out.jump     = out.jump_en ? {jsum[XLEN-1:1], jsum[0] & (dec.opcode != OPC_JALR)} : '0;
		out.store_en = is_store;
		if (is_store) begin
			out.wmask      = (dec.funct3[1:0] == 2'b00) ? 4'h1 :
				(dec.funct3[1:0] == 2'b01) ? 4'h3 : 4'hf;
			out.store_addr = src1 + dec.imm;
			out.store_data = src2;
		end
		out.csr_we    = dec.is_csr;
		out.csr_wdata = (dec.funct3 == 3'b010) ? (src1 | csr_val) : src1;
	end

endmodule

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_exec_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic [4:0]      raddr1,
	input  logic [4:0]      raddr2,
	output logic [XLEN-1:0] rdata1,
	output logic [XLEN-1:0] rdata2,
	input  logic            we,
	input  logic [4:0]      waddr,
	input  logic [XLEN-1:0] wdata
);

	// x0 has no storage behind it.
	logic [XLEN-1:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

	// a write aimed at x0 must never show up on a later read.
	a_x0_port1: assert property (@(posedge clk) disable iff (rst)
		(raddr1 == 5'd0) |-> (rdata1 == '0))
		else $error("rv_regfile: x0 read on port 1 is not zero");

	a_x0_port2: assert property (@(posedge clk) disable iff (rst)
		(raddr2 == 5'd0) |-> (rdata2 == '0))
		else $error("rv_regfile: x0 read on port 2 is not zero");

endmodule

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder import rv_exec_pkg::*; (
	input  logic [XLEN-1:0] instr,
	output decoded_t        dec
);

	opcode_e opc;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	logic csr_f3;

	assign opc = opcode_e'(instr[6:0]);

	// immediates for every format, sign taken from bit 31.
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// only csrrw and csrrs are supported in the SYSTEM space.
	assign csr_f3 = (instr[14:12] == 3'b001) || (instr[14:12] == 3'b010);

	always_comb begin
		dec          = '0;
		dec.opcode   = opc;
		dec.funct3   = instr[14:12];
		dec.funct7   = instr[31:25];
		dec.rs1      = instr[19:15];
		dec.rs2      = instr[24:20];
		dec.rd       = instr[11:7];
		dec.csr_addr = instr[31:20];
		dec.legal    = 1'b1;
		case (opc)
			OPC_LUI, OPC_AUIPC: begin
				dec.fmt   = FMT_U;
				dec.imm   = imm_u;
				dec.rd_we = 1'b1;
			end
			OPC_JAL: begin
				dec.fmt   = FMT_J;
				dec.imm   = imm_j;
				dec.rd_we = 1'b1;
			end
			OPC_JALR, OPC_OPIMM: begin
				dec.fmt   = FMT_I;
				dec.imm   = imm_i;
				dec.rd_we = 1'b1;
			end
			OPC_BRANCH: begin
				dec.fmt = FMT_B;
				dec.imm = imm_b;
			end
			OPC_STORE: begin
				dec.fmt = FMT_S;
				dec.imm = imm_s;
			end
			OPC_OP: begin
				dec.fmt   = FMT_R;
				dec.rd_we = 1'b1;
			end
			OPC_SYSTEM: begin
				dec.fmt    = FMT_I;
				dec.imm    = imm_i;
				dec.is_csr = csr_f3;
				dec.rd_we  = csr_f3;
				dec.legal  = csr_f3;
			end
			default: begin
				// Unknown opcode, nothing is written.
				dec.fmt   = FMT_R;
				dec.legal = 1'b0;
			end
		endcase
	end

endmodule

// ==== rtl/rv_exec_pkg.sv ====
package rv_exec_pkg;

	// RV32 fixes the datapath width for every block.
	localparam int XLEN = 32;

	// major opcodes, taken straight from instr[6:0].
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_STORE  = 7'b0100011,
		OPC_OPIMM  = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		FMT_R = 3'd0,
		FMT_I = 3'd1,
		FMT_S = 3'd2,
		FMT_B = 3'd3,
		FMT_U = 3'd4,
		FMT_J = 3'd5
	} fmt_e;

	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_XOR   = 4'd3,
		ALU_OR    = 4'd4,
		ALU_SRL   = 4'd5,
		ALU_SRA   = 4'd6,
		ALU_SLL   = 4'd7,
		ALU_LESS  = 4'd8,
		ALU_ULESS = 4'd9
	} alu_op_e;

	// machine CSRs held by the CSR file.
	localparam logic [11:0] CSR_MSTATUS = 12'h300;
	localparam logic [11:0] CSR_MTVEC   = 12'h305;
	localparam logic [11:0] CSR_MEPC    = 12'h341;
	localparam logic [11:0] CSR_MCAUSE  = 12'h342;

	typedef struct packed {
		logic [XLEN-1:0] instr;
		logic [XLEN-1:0] pc;
	} cmd_t;

	typedef struct packed {
		opcode_e         opcode;
		fmt_e            fmt;
		logic [2:0]      funct3;
		logic [6:0]      funct7;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      rd;
		logic [XLEN-1:0] imm;
		logic [11:0]     csr_addr;
		logic            rd_we;
		logic            is_csr;
		logic            legal;
	} decoded_t;

	typedef struct packed {
		logic [XLEN-1:0] val;
		logic            jump_en;
		logic [XLEN-1:0] jump;
		logic            store_en;
		logic [3:0]      wmask;
		logic [XLEN-1:0] store_addr;
		logic [XLEN-1:0] store_data;
		logic            csr_we;
		logic [XLEN-1:0] csr_wdata;
	} exu_out_t;

	typedef struct packed {
		logic [4:0]      rd;
		logic            rd_we;
		logic [XLEN-1:0] rd_val;
		logic [XLEN-1:0] next_pc;
		logic            store_en;
		logic [3:0]      wmask;
		logic [XLEN-1:0] store_addr;
		logic [XLEN-1:0] store_data;
		logic            illegal;
	} result_t;

endpackage
